//--- Makefile
# Verilator flow for the peripheral subsystem

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= periph_tb
RTL_TOP   ?= periph_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- source/gpio.sv
`timescale 1ns/1ps

module gpio (
    input  logic        clk,
    input  logic        rst_i,
    periph_bus_if.dev   bus,
    input  logic [31:0] gpio_i,
    output logic [31:0] gpio_o
);

    import periph_pkg::*;

    // register offsets
    localparam logic [3:0] REG_OUT = 4'h0;
    localparam logic [3:0] REG_IN  = 4'h4;

    // output data, offset 0x0
    word_t out_q;
    // first sync stage
    word_t sync_q;
    // synced input, offset 0x4, read only
    word_t in_q;

    // pins follow the register directly
    assign gpio_o = out_q;

    // output register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= ZERO_WORD;
        end else if (bus.we && (bus.addr[3:0] == REG_OUT)) begin
            out_q <= bus.wdata;
        end
    end

    // two-flop input synchronizer
    // new pin value lands in in_q on the second edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_q <= ZERO_WORD;
            in_q   <= ZERO_WORD;
        end else begin
            sync_q <= gpio_i;
            in_q   <= sync_q;
        end
    end

    // read mux on offset
    always_comb begin
        case (bus.addr[3:0])
            REG_OUT: bus.rdata = out_q;
            REG_IN:  bus.rdata = in_q;
            default: bus.rdata = ZERO_WORD;
        endcase
    end

endmodule

//--- source/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if;

    import periph_pkg::*;

    // full address, peripheral looks at low nibble only
    word_t addr;
    word_t wdata;
    // write strobe, already qualified by the decoder
    logic  we;
    // combinational read data
    word_t rdata;

    // decoder side
    modport host (
        output addr, wdata, we,
        input  rdata
    );

    // peripheral side
    modport dev (
        input  addr, wdata, we,
        output rdata
    );

endinterface

//--- source/periph_decoder.sv
`timescale 1ns/1ps

module periph_decoder #(
    parameter logic [3:0] TIMER_BASE = periph_pkg::TIMER_NIBBLE,
    parameter logic [3:0] GPIO_BASE  = periph_pkg::GPIO_NIBBLE
) (
    input  logic                rst_i,
    input  periph_pkg::word_t   addr_i,
    input  periph_pkg::word_t   wdata_i,
    input  logic                we_i,
    output periph_pkg::word_t   rdata_o,
    periph_bus_if.host          timer_bus,
    periph_bus_if.host          gpio_bus
);

    import periph_pkg::*;

    logic timer_hit;
    logic gpio_hit;

    // region select on top nibble
    assign timer_hit = (addr_i[31:28] == TIMER_BASE);
    assign gpio_hit  = (addr_i[31:28] == GPIO_BASE);

    // address and data fan out to both
    assign timer_bus.addr  = addr_i;
    assign timer_bus.wdata = wdata_i;
    assign gpio_bus.addr   = addr_i;
    assign gpio_bus.wdata  = wdata_i;

    // strobe only to the selected peripheral
    assign timer_bus.we = we_i & timer_hit;
    assign gpio_bus.we  = we_i & gpio_hit;

    // read mux, same cycle as the address
    always_comb begin
        if (rst_i) begin
            // bus reads zero while in reset
            rdata_o = ZERO_WORD;
        end else if (timer_hit) begin
            rdata_o = timer_bus.rdata;
        end else if (gpio_hit) begin
            rdata_o = gpio_bus.rdata;
        end else begin
            // unmapped region
            rdata_o = ZERO_WORD;
        end
    end

endmodule

//--- source/periph_pkg.sv
package periph_pkg;

    // one bus word
    typedef logic [31:0] word_t;

    // timer control register, bit fields
    typedef struct packed {
        logic [28:0] rsvd;
        // sticky, write one to clear
        logic        pending;
        // interrupt mask
        logic        int_en;
        // counter run, cleared by hw on expiry
        logic        enable;
    } timer_ctrl_fields_t;

    // same control word, raw for the bus, fields for the logic
    typedef union packed {
        word_t              raw;
        timer_ctrl_fields_t fields;
    } timer_ctrl_u;

    localparam word_t ZERO_WORD = 32'h0000_0000;

    // default address map, bits 31:28
    localparam logic [3:0] TIMER_NIBBLE = 4'h2;
    localparam logic [3:0] GPIO_NIBBLE  = 4'h4;

endpackage

//--- source/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter logic [3:0] TIMER_BASE = periph_pkg::TIMER_NIBBLE,
    parameter logic [3:0] GPIO_BASE  = periph_pkg::GPIO_NIBBLE
) (
    input  logic                clk,
    input  logic                rst_i,
    // register bus from the core
    input  periph_pkg::word_t   addr_i,
    input  periph_pkg::word_t   wdata_i,
    input  logic                we_i,
    output periph_pkg::word_t   rdata_o,
    // pins
    input  logic [31:0]         gpio_i,
    output logic [31:0]         gpio_o,
    // timer irq, level
    output logic                int_o
);

    // one bus per peripheral
    periph_bus_if timer_bus ();
    periph_bus_if gpio_bus ();

    // address decode and read mux
    periph_decoder #(
        .TIMER_BASE (TIMER_BASE),
        .GPIO_BASE  (GPIO_BASE)
    ) i_periph_decoder (
        .rst_i      (rst_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .we_i       (we_i),
        .rdata_o    (rdata_o),
        .timer_bus  (timer_bus.host),
        .gpio_bus   (gpio_bus.host)
    );

    timer i_timer (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (timer_bus.dev),
        .int_o      (int_o)
    );

    gpio i_gpio (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (gpio_bus.dev),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o)
    );

endmodule

//--- source/timer.sv
`timescale 1ns/1ps

module timer (
    input  logic        clk,
    input  logic        rst_i,
    periph_bus_if.dev   bus,
    output logic        int_o
);

    import periph_pkg::*;

    // register offsets
    localparam logic [3:0] REG_CTRL  = 4'h0;
    localparam logic [3:0] REG_COUNT = 4'h4;
    localparam logic [3:0] REG_VALUE = 4'h8;

    // control, offset 0x0
    timer_ctrl_u ctrl;
    // running count, offset 0x4, read only
    word_t       count;
    // compare value, offset 0x8
    word_t       value;

    // incoming write word seen as ctrl fields
    timer_ctrl_u wr_ctrl;
    logic        expired;

    assign wr_ctrl.raw = bus.wdata;

    // count reached compare while running
    assign expired = ctrl.fields.enable && (count >= value);

    // level interrupt, masked by int_en
    assign int_o = ctrl.fields.pending & ctrl.fields.int_en;

    // counter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            count <= ZERO_WORD;
        end else if (expired) begin
            // wrap back on expiry
            count <= ZERO_WORD;
        end else if (ctrl.fields.enable) begin
            count <= count + 1'b1;
        end else begin
            // stopped timer holds zero
            count <= ZERO_WORD;
        end
    end

    // ctrl and value registers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl.raw <= ZERO_WORD;
            value    <= ZERO_WORD;
        end else if (bus.we) begin
            // bus write wins over a same-edge expiry
            case (bus.addr[3:0])
                REG_CTRL: begin
                    ctrl.fields.rsvd    <= '0;
                    // w1c, sw can only clear
                    ctrl.fields.pending <= ctrl.fields.pending & ~wr_ctrl.fields.pending;
                    ctrl.fields.int_en  <= wr_ctrl.fields.int_en;
                    ctrl.fields.enable  <= wr_ctrl.fields.enable;
                end
                REG_VALUE: begin
                    value <= bus.wdata;
                end
                default: begin
                    // count and unused offsets ignore writes
                end
            endcase
        end else if (expired) begin
            // one-shot: stop and flag
            ctrl.fields.enable  <= 1'b0;
            ctrl.fields.pending <= 1'b1;
        end
    end

    // read mux on offset
    always_comb begin
        case (bus.addr[3:0])
            REG_CTRL:  bus.rdata = ctrl.raw;
            REG_COUNT: bus.rdata = count;
            REG_VALUE: bus.rdata = value;
            default:   bus.rdata = ZERO_WORD;
        endcase
    end

endmodule

//--- test/periph_sva.sv
`timescale 1ns/1ps

module periph_sva (
    input logic                    clk,
    input logic                    rst_i,
    input periph_pkg::timer_ctrl_u ctrl_i,
    input periph_pkg::word_t       count_i,
    input periph_pkg::word_t       value_i,
    input logic                    we_i,
    input logic                    int_i
);

    logic expiry;

    // running and count at or past compare
    assign expiry = ctrl_i.fields.enable && (count_i >= value_i);

    // irq only rises on an unmasked expiry and only falls on a bus write
    a_int_level: assert property (
        @(posedge clk) disable iff (rst_i)
        !we_i |=> int_i == ($past(int_i) || ($past(expiry) && ctrl_i.fields.int_en))
    ) else $error("int_o changed without an unmasked expiry or a bus write");

    // running counter stays within compare
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst_i)
        ctrl_i.fields.enable |-> (count_i <= value_i)
    ) else $error("count above compare value while enabled");

    // a bus write on the same edge takes priority
    a_expiry_pending: assert property (
        @(posedge clk) disable iff (rst_i)
        (expiry && !we_i) |=> ctrl_i.fields.pending
    ) else $error("expiry did not set pending on the next edge");

endmodule

bind timer periph_sva i_periph_sva (
    .clk     (clk),
    .rst_i   (rst_i),
    .ctrl_i  (ctrl),
    .count_i (count),
    .value_i (value),
    .we_i    (bus.we),
    .int_i   (int_o)
);

//--- test/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

    // input drive point after each rising edge
    localparam int DRIVE_DLY = 10;
    // expiry runs ~8 x 30, count runs ~4 x 45, rest ~150; about 3x margin
    localparam int TIMEOUT_CYCLES = 2000;

    // register addresses, timer at 0x2, gpio at 0x4
    localparam logic [31:0] A_CTRL  = 32'h2000_0000;
    localparam logic [31:0] A_COUNT = 32'h2000_0004;
    localparam logic [31:0] A_VALUE = 32'h2000_0008;
    localparam logic [31:0] A_OUT   = 32'h4000_0000;
    localparam logic [31:0] A_IN    = 32'h4000_0004;
    // ctrl bits
    localparam logic [31:0] C_EN    = 32'h1;
    localparam logic [31:0] C_IE    = 32'h2;
    localparam logic [31:0] C_PEND  = 32'h4;

    logic        clk;
    logic        rst;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [31:0] rdata;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic        irq;
    logic [31:0] lfsr_q;
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_o (rst)
    );

    periph_top i_periph_top (
        .clk     (clk),
        .rst_i   (rst),
        .addr_i  (addr),
        .wdata_i (wdata),
        .we_i    (we),
        .rdata_o (rdata),
        .gpio_i  (gpio_in),
        .gpio_o  (gpio_out),
        .int_o   (irq)
    );

    // fibonacci, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // taken at the next edge
    task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
        addr  = a;
        wdata = d;
        we    = 1'b1;
        next_edge();
        we    = 1'b0;
    endtask

    // read data is combinational, sampled mid cycle
    task automatic read_check(input logic [31:0] a, input logic [31:0] exp, input string msg);
        addr = a;
        we   = 1'b0;
        @(negedge clk);
        check_value(rdata, exp, msg);
        next_edge();
    endtask

    task automatic reset_test();
        // regs are still unknown before the first edge, only the forced zero shows
        addr = A_VALUE;
        #(DRIVE_DLY);
        check_value(rdata, 0, "read before first reset edge");
        next_edge();
        check_value(irq, 0, "int_o in reset");
        read_check(A_VALUE, 0, "read in reset");
        wait (!rst);
        read_check(A_CTRL, 0, "CTRL after reset");
        read_check(A_COUNT, 0, "COUNT after reset");
        read_check(A_VALUE, 0, "VALUE after reset");
        read_check(A_OUT, 0, "OUT after reset");
        read_check(A_IN, 0, "IN after reset");
        check_value(irq, 0, "int_o after reset");
    endtask

    task automatic register_test();
        logic [31:0] val;
        logic [31:0] out;
        for (int i = 0; i < 4; i++) begin
            val = rand_bits(32);
            write_reg(A_VALUE, val);
            read_check(A_VALUE, val, "VALUE readback");
            out = rand_bits(32);
            write_reg(A_OUT, out);
            check_value(gpio_out, out, "gpio_o after OUT write");
            read_check(A_OUT, out, "OUT readback");
        end
        // unmapped nibble, unused offsets, read-only registers
        write_reg(32'h3000_0000, rand_bits(32));
        read_check(32'h3000_0000, 0, "unmapped nibble");
        read_check(32'h2000_000c, 0, "unused timer offset");
        read_check(32'h4000_0008, 0, "unused gpio offset");
        write_reg(A_COUNT, rand_bits(32));
        read_check(A_COUNT, 0, "COUNT after write");
        write_reg(A_IN, rand_bits(32));
        read_check(A_IN, 0, "IN after write");
        read_check(A_OUT, out, "OUT after stray writes");
        read_check(A_CTRL, 0, "CTRL after stray writes");
    endtask

    // pending rises v+1 edges after the edge that takes the enable
    task automatic expiry_test();
        logic [31:0] v;
        for (int i = 0; i < 8; i++) begin
            v = rand_bits(4);
            write_reg(A_VALUE, v);
            write_reg(A_CTRL, C_EN | C_IE);
            check_value(irq, 0, $sformatf("int_o early, V=%0d", v));
            repeat (v) begin
                next_edge();
                check_value(irq, 0, $sformatf("int_o early, V=%0d", v));
            end
            repeat (3) begin
                next_edge();
                check_value(irq, 1, $sformatf("int_o after expiry, V=%0d", v));
            end
            read_check(A_CTRL, C_IE | C_PEND, "CTRL after expiry");
            read_check(A_COUNT, 0, "COUNT after expiry");
            write_reg(A_CTRL, C_PEND);
            check_value(irq, 0, "int_o after clear");
        end
    endtask

    task automatic mask_test();
        logic [31:0] v;
        v = 3 + rand_bits(3);
        write_reg(A_VALUE, v);
        write_reg(A_CTRL, C_EN);
        repeat (v + 1) next_edge();
        check_value(irq, 0, "int_o while masked");
        read_check(A_CTRL, C_PEND, "CTRL masked expiry");
        write_reg(A_CTRL, C_IE);
        check_value(irq, 1, "int_o after unmask");
        read_check(A_CTRL, C_IE | C_PEND, "CTRL after unmask");
        write_reg(A_CTRL, C_IE | C_PEND);
        check_value(irq, 0, "int_o after w1c");
        read_check(A_CTRL, C_IE, "CTRL after w1c");
        // write on the expiry edge drops that expiry
        write_reg(A_CTRL, C_EN);
        repeat (v) next_edge();
        write_reg(A_CTRL, C_IE);
        read_check(A_CTRL, C_IE, "CTRL write on expiry edge");
        check_value(irq, 0, "int_o write on expiry edge");
        write_reg(A_CTRL, 0);
    endtask

    task automatic count_test();
        logic [31:0] k;
        for (int i = 0; i < 4; i++) begin
            k = 2 + rand_bits(5);
            write_reg(A_VALUE, 32'h8000_0000 | rand_bits(32));
            write_reg(A_CTRL, C_EN);
            // enable edge is the first of k
            repeat (k - 1) next_edge();
            read_check(A_COUNT, k - 1, $sformatf("COUNT after %0d edges", k));
            write_reg(A_CTRL, 0);
            // disabling edge still steps once
            read_check(A_COUNT, k + 1, "COUNT on disable edge");
            read_check(A_COUNT, 0, "COUNT after disable");
        end
    endtask

    task automatic gpio_sync_test();
        logic [31:0] d;
        logic [31:0] prev;
        prev = gpio_in;
        for (int i = 0; i < 4; i++) begin
            d = rand_bits(32);
            gpio_in = d;
            read_check(A_IN, prev, "IN before first edge");
            read_check(A_IN, prev, "IN after one edge");
            read_check(A_IN, d, "IN after two edges");
            prev = d;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        lfsr_q    = 32'hdc1b_287d;
        n_checks  = 0;
        n_errors  = 0;
        cycle_cnt = 0;
        addr      = '0;
        wdata     = '0;
        we        = 1'b0;
        gpio_in   = '0;
        reset_test();
        register_test();
        expiry_test();
        mask_test();
        count_test();
        gpio_sync_test();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset held over two rising edges, dropped at the usual drive point
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst_o = 1'b0;
    end

endmodule

//--- vlog.f
source/periph_pkg.sv
source/periph_bus_if.sv
source/periph_decoder.sv
source/timer.sv
source/gpio.sv
source/periph_top.sv
test/tb_clock_gen.sv
test/periph_sva.sv
test/periph_tb.sv
